// File: pcie_tlp_pkg.sv
// PCIe TLP package for the host-channel multiplexer
// Holds the single-beat TLP word type, its field positions, the kind codes
// and the number of AFU functions that share the emulated port
package pcie_tlp_pkg;

    // One simplified TLP is a single 64-bit beat
    typedef logic [63:0] tlp_t;

    // Kind code in bits 63..56
    typedef logic [7:0] tlp_kind_t;

    // Function number in bits 55..48, stamped by the PF/VF mux on TX
    typedef logic [7:0] func_num_t;

    // Tag in bits 47..40, echoed by completions and commits
    typedef logic [7:0] tlp_tag_t;

    // Address or data in bits 31..0
    typedef logic [31:0] tlp_payload_t;

    // Field positions inside tlp_t
    // Bits 39..32 are reserved and pass through untouched
    localparam int KIND_LSB = 56;
    localparam int FUNC_LSB = 48;
    localparam int TAG_LSB  = 40;

    // Memory write, needs a local commit once it is ordered
    localparam tlp_kind_t KIND_MWR = 8'h40;

    // Memory read, answered by a completion on RX A
    localparam tlp_kind_t KIND_MRD = 8'h00;

    // Completion from the host
    localparam tlp_kind_t KIND_CPL = 8'h4a;

    // Locally generated write commit on RX B
    localparam tlp_kind_t KIND_CMT = 8'h7f;

    // Number of AFU functions behind each lane mux
    localparam int NUM_FUNCS = 2;

endpackage

// File: pf_vf_mux.sv
// PF/VF function mux for one lane of the host channel
// TX: round-robin arbitration over the functions into a one-beat output
// register, with the winning function number stamped into each TLP
// RX: combinational routing of lane TLPs to the function named in the TLP
`timescale 1ns/1ps

module pf_vf_mux
(
    input  logic                clk,
    input  logic                rst_n,

    input  logic                fn_tx_valid [pcie_tlp_pkg::NUM_FUNCS],
    input  pcie_tlp_pkg::tlp_t  fn_tx_data  [pcie_tlp_pkg::NUM_FUNCS],
    output logic                fn_tx_ready [pcie_tlp_pkg::NUM_FUNCS],

    output logic                lane_tx_valid,
    output pcie_tlp_pkg::tlp_t  lane_tx_data,
    input  logic                lane_tx_ready,

    input  logic                lane_rx_valid,
    input  pcie_tlp_pkg::tlp_t  lane_rx_data,
    output logic                lane_rx_ready,

    output logic                fn_rx_valid [pcie_tlp_pkg::NUM_FUNCS],
    output pcie_tlp_pkg::tlp_t  fn_rx_data  [pcie_tlp_pkg::NUM_FUNCS],
    input  logic                fn_rx_ready [pcie_tlp_pkg::NUM_FUNCS]
);

    pcie_tlp_pkg::func_num_t last_grant;
    pcie_tlp_pkg::func_num_t grant_idx;
    logic                    grant_found;
    logic                    tx_load;
    pcie_tlp_pkg::tlp_t      tx_stamped;
    pcie_tlp_pkg::func_num_t rx_func;

    // The output register can take a new beat when empty or when its beat leaves
    assign tx_load = !lane_tx_valid || lane_tx_ready;

    // Round-robin pick, lowest index wins within each pass
    // The second pass covers functions above the last grant and overrides the first,
    // so the function right after the last winner has top priority
    always_comb
    begin
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int i = pcie_tlp_pkg::NUM_FUNCS - 1; i >= 0; i--)
        begin
            if (fn_tx_valid[i] && (pcie_tlp_pkg::func_num_t'(i) <= last_grant))
            begin
                grant_found = 1'b1;
                grant_idx   = pcie_tlp_pkg::func_num_t'(i);
            end
        end
        for (int i = pcie_tlp_pkg::NUM_FUNCS - 1; i >= 0; i--)
        begin
            if (fn_tx_valid[i] && (pcie_tlp_pkg::func_num_t'(i) > last_grant))
            begin
                grant_found = 1'b1;
                grant_idx   = pcie_tlp_pkg::func_num_t'(i);
            end
        end
    end

    // Select the winner's word and overwrite its func field with the port index
    always_comb
    begin
        tx_stamped = '0;
        for (int i = 0; i < pcie_tlp_pkg::NUM_FUNCS; i++)
        begin
            if (grant_idx == pcie_tlp_pkg::func_num_t'(i))
                tx_stamped = fn_tx_data[i];
        end
        tx_stamped[pcie_tlp_pkg::FUNC_LSB +: $bits(pcie_tlp_pkg::func_num_t)] = grant_idx;
    end

    // Only the winner sees ready, and only while the output register can load
    for (genvar g = 0; g < pcie_tlp_pkg::NUM_FUNCS; g++)
    begin : g_tx_ready
        assign fn_tx_ready[g] = tx_load && grant_found &&
                                (grant_idx == pcie_tlp_pkg::func_num_t'(g));
    end

    // Output valid and the round-robin pointer
    // Starting at the top index makes function 0 the first winner after reset
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            lane_tx_valid <= 1'b0;
            last_grant    <= pcie_tlp_pkg::func_num_t'(pcie_tlp_pkg::NUM_FUNCS - 1);
        end
        else if (tx_load)
        begin
            lane_tx_valid <= grant_found;
            if (grant_found)
                last_grant <= grant_idx;
        end
    end

    always_ff @(posedge clk)
    begin
        if (tx_load && grant_found)
            lane_tx_data <= tx_stamped;
    end

    // RX side decodes the func field, no storage
    assign rx_func = lane_rx_data[pcie_tlp_pkg::FUNC_LSB +: $bits(pcie_tlp_pkg::func_num_t)];

    for (genvar g = 0; g < pcie_tlp_pkg::NUM_FUNCS; g++)
    begin : g_rx_route
        assign fn_rx_valid[g] = lane_rx_valid && (rx_func == pcie_tlp_pkg::func_num_t'(g));
        assign fn_rx_data[g]  = lane_rx_data;
    end

    // Ready comes from the addressed function only
    // A TLP for a function that does not exist is dropped so the lane keeps moving
    always_comb
    begin
        lane_rx_ready = 1'b1;
        for (int i = 0; i < pcie_tlp_pkg::NUM_FUNCS; i++)
        begin
            if (rx_func == pcie_tlp_pkg::func_num_t'(i))
                lane_rx_ready = fn_rx_ready[i];
        end
    end

    // The host or the commit stage must only address functions that exist
    rx_func_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        lane_rx_valid |-> (rx_func < pcie_tlp_pkg::NUM_FUNCS)
    ) else $error("RX TLP for function %0d, only %0d functions",
                  rx_func, pcie_tlp_pkg::NUM_FUNCS);

endmodule

// File: tx_ab_arb.sv
// A/B TX merge for the host channel
// Two-way round-robin between the lane A and lane B TX streams into one
// registered output, one cycle from acceptance to output
`timescale 1ns/1ps

module tx_ab_arb
(
    input  logic               clk,
    input  logic               rst_n,

    input  logic               a_valid,
    input  pcie_tlp_pkg::tlp_t a_data,
    output logic               a_ready,

    input  logic               b_valid,
    input  pcie_tlp_pkg::tlp_t b_data,
    output logic               b_ready,

    output logic               out_valid,
    output pcie_tlp_pkg::tlp_t out_data,
    input  logic               out_ready
);

    logic prio_b;
    logic load;
    logic grant_a;
    logic grant_b;

    // Register is free when empty or when its beat leaves this cycle
    assign load = !out_valid || out_ready;

    // B wins when alone or when it holds priority, A takes everything else
    assign grant_b = b_valid && (!a_valid || prio_b);
    assign grant_a = a_valid && !grant_b;

    assign a_ready = load && grant_a;
    assign b_ready = load && grant_b;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            prio_b    <= 1'b0;
        end
        else if (load)
        begin
            out_valid <= grant_a || grant_b;
            // Flip priority only when both lanes competed for this slot
            if (a_valid && b_valid)
                prio_b <= !prio_b;
        end
    end

    always_ff @(posedge clk)
    begin
        if (a_ready && a_valid)
            out_data <= a_data;
        else if (b_ready && b_valid)
            out_data <= b_data;
    end

    // A stalled beat must hold until the commit stage takes it
    out_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    ) else $error("Merged TX beat changed while stalled");

endmodule

// File: local_commit.sv
// Local commit stage at the end of the merged TX path
// Registers each TX beat toward the host and, for every memory write,
// loads a commit TLP with the same function and tag into a one-entry
// register that drives RX lane B
`timescale 1ns/1ps

module local_commit
(
    input  logic               clk,
    input  logic               rst_n,

    input  logic               in_valid,
    input  pcie_tlp_pkg::tlp_t in_data,
    output logic               in_ready,

    output logic               host_valid,
    output pcie_tlp_pkg::tlp_t host_data,
    input  logic               host_ready,

    output logic               commit_valid,
    output pcie_tlp_pkg::tlp_t commit_data,
    input  logic               commit_ready
);

    pcie_tlp_pkg::tlp_kind_t in_kind;
    pcie_tlp_pkg::func_num_t in_func;
    pcie_tlp_pkg::tlp_tag_t  in_tag;
    logic                    is_mwr;
    logic                    tx_free;
    logic                    cmt_free;
    logic                    accept;
    pcie_tlp_pkg::tlp_t      commit_word;

    assign in_kind = in_data[pcie_tlp_pkg::KIND_LSB +: $bits(pcie_tlp_pkg::tlp_kind_t)];
    assign in_func = in_data[pcie_tlp_pkg::FUNC_LSB +: $bits(pcie_tlp_pkg::func_num_t)];
    assign in_tag  = in_data[pcie_tlp_pkg::TAG_LSB +: $bits(pcie_tlp_pkg::tlp_tag_t)];
    assign is_mwr  = (in_kind == pcie_tlp_pkg::KIND_MWR);

    // Each slot is free when empty or draining in this cycle
    assign tx_free  = !host_valid || host_ready;
    assign cmt_free = !commit_valid || commit_ready;

    // Writes need room for both the TX beat and its commit
    assign in_ready = tx_free && (!is_mwr || cmt_free);
    assign accept   = in_valid && in_ready;

    // Commit word carries the writer's function and tag with reserved and payload zero
    always_comb
    begin
        commit_word = '0;
        commit_word[pcie_tlp_pkg::KIND_LSB +: $bits(pcie_tlp_pkg::tlp_kind_t)] =
            pcie_tlp_pkg::KIND_CMT;
        commit_word[pcie_tlp_pkg::FUNC_LSB +: $bits(pcie_tlp_pkg::func_num_t)] = in_func;
        commit_word[pcie_tlp_pkg::TAG_LSB +: $bits(pcie_tlp_pkg::tlp_tag_t)]   = in_tag;
        commit_word[0 +: $bits(pcie_tlp_pkg::tlp_payload_t)] = '0;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            host_valid   <= 1'b0;
            commit_valid <= 1'b0;
        end
        else
        begin
            if (tx_free)
                host_valid <= accept;
            // A new commit replaces one that drains in the same cycle
            if (accept && is_mwr)
                commit_valid <= 1'b1;
            else if (commit_ready)
                commit_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            host_data <= in_data;
        if (accept && is_mwr)
            commit_data <= commit_word;
    end

    // A commit that waits for its function stays in place until it is taken
    // A write that slipped in while the slot was blocked would overwrite it
    mwr_commit_slot: assert property (
        @(posedge clk) disable iff (!rst_n)
        (commit_valid && !commit_ready) |=> (commit_valid && $stable(commit_data))
    ) else $error("Write accepted while the commit register was full and not draining");

endmodule

// File: host_chan_mux_top.sv
// Host-channel multiplexer top level
// Reduces the per-function A and B TLP streams of the AFU to the single
// TX/RX pair of one emulated PCIe port: a PF/VF mux per lane, an A/B merge
// of the lane TX streams and a local commit stage that answers memory
// writes on RX lane B
`timescale 1ns/1ps

module host_chan_mux_top
(
    input  logic               clk,
    input  logic               rst_n,

    // AFU TX streams, lane A
    input  logic               afu_tx_a_valid [pcie_tlp_pkg::NUM_FUNCS],
    input  pcie_tlp_pkg::tlp_t afu_tx_a_data  [pcie_tlp_pkg::NUM_FUNCS],
    output logic               afu_tx_a_ready [pcie_tlp_pkg::NUM_FUNCS],

    // AFU TX streams, lane B
    input  logic               afu_tx_b_valid [pcie_tlp_pkg::NUM_FUNCS],
    input  pcie_tlp_pkg::tlp_t afu_tx_b_data  [pcie_tlp_pkg::NUM_FUNCS],
    output logic               afu_tx_b_ready [pcie_tlp_pkg::NUM_FUNCS],

    // AFU RX streams, lane A carries host completions
    output logic               afu_rx_a_valid [pcie_tlp_pkg::NUM_FUNCS],
    output pcie_tlp_pkg::tlp_t afu_rx_a_data  [pcie_tlp_pkg::NUM_FUNCS],
    input  logic               afu_rx_a_ready [pcie_tlp_pkg::NUM_FUNCS],

    // AFU RX streams, lane B carries local commits only
    output logic               afu_rx_b_valid [pcie_tlp_pkg::NUM_FUNCS],
    output pcie_tlp_pkg::tlp_t afu_rx_b_data  [pcie_tlp_pkg::NUM_FUNCS],
    input  logic               afu_rx_b_ready [pcie_tlp_pkg::NUM_FUNCS],

    // Merged TX toward the host port
    output logic               host_tx_valid,
    output pcie_tlp_pkg::tlp_t host_tx_data,
    input  logic               host_tx_ready,

    // RX from the host port
    input  logic               host_rx_a_valid,
    input  pcie_tlp_pkg::tlp_t host_rx_a_data,
    output logic               host_rx_a_ready
);

    // Lane TX outputs of the two muxes
    logic               lane_tx_a_valid;
    pcie_tlp_pkg::tlp_t lane_tx_a_data;
    logic               lane_tx_a_ready;
    logic               lane_tx_b_valid;
    pcie_tlp_pkg::tlp_t lane_tx_b_data;
    logic               lane_tx_b_ready;

    // A/B merged stream before the commit stage
    logic               merged_tx_valid;
    pcie_tlp_pkg::tlp_t merged_tx_data;
    logic               merged_tx_ready;

    // Synthesized commits into lane B RX
    logic               commit_rx_valid;
    pcie_tlp_pkg::tlp_t commit_rx_data;
    logic               commit_rx_ready;

    // Lane A, host completions come back through here
    pf_vf_mux mux_a
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .fn_tx_valid   (afu_tx_a_valid),
        .fn_tx_data    (afu_tx_a_data),
        .fn_tx_ready   (afu_tx_a_ready),
        .lane_tx_valid (lane_tx_a_valid),
        .lane_tx_data  (lane_tx_a_data),
        .lane_tx_ready (lane_tx_a_ready),
        .lane_rx_valid (host_rx_a_valid),
        .lane_rx_data  (host_rx_a_data),
        .lane_rx_ready (host_rx_a_ready),
        .fn_rx_valid   (afu_rx_a_valid),
        .fn_rx_data    (afu_rx_a_data),
        .fn_rx_ready   (afu_rx_a_ready)
    );

    // Lane B, its RX side is fed by the commit stage
    pf_vf_mux mux_b
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .fn_tx_valid   (afu_tx_b_valid),
        .fn_tx_data    (afu_tx_b_data),
        .fn_tx_ready   (afu_tx_b_ready),
        .lane_tx_valid (lane_tx_b_valid),
        .lane_tx_data  (lane_tx_b_data),
        .lane_tx_ready (lane_tx_b_ready),
        .lane_rx_valid (commit_rx_valid),
        .lane_rx_data  (commit_rx_data),
        .lane_rx_ready (commit_rx_ready),
        .fn_rx_valid   (afu_rx_b_valid),
        .fn_rx_data    (afu_rx_b_data),
        .fn_rx_ready   (afu_rx_b_ready)
    );

    tx_ab_arb tx_ab_merge
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_valid   (lane_tx_a_valid),
        .a_data    (lane_tx_a_data),
        .a_ready   (lane_tx_a_ready),
        .b_valid   (lane_tx_b_valid),
        .b_data    (lane_tx_b_data),
        .b_ready   (lane_tx_b_ready),
        .out_valid (merged_tx_valid),
        .out_data  (merged_tx_data),
        .out_ready (merged_tx_ready)
    );

    // Commits are generated after A/B ordering is final
    local_commit commit_gen
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (merged_tx_valid),
        .in_data      (merged_tx_data),
        .in_ready     (merged_tx_ready),
        .host_valid   (host_tx_valid),
        .host_data    (host_tx_data),
        .host_ready   (host_tx_ready),
        .commit_valid (commit_rx_valid),
        .commit_data  (commit_rx_data),
        .commit_ready (commit_rx_ready)
    );

endmodule

// File: tb_host_chan_mux.sv
// Testbench for the host-channel multiplexer
// Plays the AFU on both lanes and the host on the single port, and checks
// function stamping, per-stream order, commit generation for memory writes
// and completion routing under random back-pressure
`timescale 1ns/1ps

module tb_host_chan_mux;

    logic               clk = 1'b0;
    logic               rst_n;

    logic               afu_tx_a_valid [pcie_tlp_pkg::NUM_FUNCS];
    pcie_tlp_pkg::tlp_t afu_tx_a_data  [pcie_tlp_pkg::NUM_FUNCS];
    logic               afu_tx_a_ready [pcie_tlp_pkg::NUM_FUNCS];
    logic               afu_tx_b_valid [pcie_tlp_pkg::NUM_FUNCS];
    pcie_tlp_pkg::tlp_t afu_tx_b_data  [pcie_tlp_pkg::NUM_FUNCS];
    logic               afu_tx_b_ready [pcie_tlp_pkg::NUM_FUNCS];
    logic               afu_rx_a_valid [pcie_tlp_pkg::NUM_FUNCS];
    pcie_tlp_pkg::tlp_t afu_rx_a_data  [pcie_tlp_pkg::NUM_FUNCS];
    logic               afu_rx_a_ready [pcie_tlp_pkg::NUM_FUNCS];
    logic               afu_rx_b_valid [pcie_tlp_pkg::NUM_FUNCS];
    pcie_tlp_pkg::tlp_t afu_rx_b_data  [pcie_tlp_pkg::NUM_FUNCS];
    logic               afu_rx_b_ready [pcie_tlp_pkg::NUM_FUNCS];
    logic               host_tx_valid;
    pcie_tlp_pkg::tlp_t host_tx_data;
    logic               host_tx_ready;
    logic               host_rx_a_valid;
    pcie_tlp_pkg::tlp_t host_rx_a_data;
    logic               host_rx_a_ready;

    // Stimulus columns are lane, function, kind, tag and payload (8/8/8/8/32 bits)
    // Tags are unique, so a host TX beat can be matched to the head of its stream
    logic [63:0] stim_table [24] = '{
        64'h00_00_40_01_0000_1000, 64'h00_01_00_41_0000_2000,
        64'h01_00_40_81_0000_3000, 64'h01_01_40_c1_0000_4000,
        64'h00_00_00_02_0000_1040, 64'h00_01_40_42_0000_2040,
        64'h01_00_40_82_0000_3040, 64'h01_01_00_c2_0000_4040,
        64'h00_00_40_03_0000_1080, 64'h00_01_40_43_0000_2080,
        64'h01_00_00_83_0000_3080, 64'h01_01_40_c3_0000_4080,
        64'h00_00_40_04_0000_10c0, 64'h00_01_00_44_0000_20c0,
        64'h01_00_40_84_0000_30c0, 64'h01_01_40_c4_0000_40c0,
        64'h00_00_00_05_0000_1100, 64'h00_01_40_45_0000_2100,
        64'h01_00_40_85_0000_3100, 64'h01_01_00_c5_0000_4100,
        64'h00_00_40_06_0000_1140, 64'h00_01_40_46_0000_2140,
        64'h01_00_00_86_0000_3140, 64'h01_01_40_c6_0000_4140
    };

    // Host completions name their function and echo a read tag
    pcie_tlp_pkg::tlp_t cpl_table [8] = '{
        64'h4a_00_02_00_c000_0002, 64'h4a_01_41_00_c000_0041,
        64'h4a_00_83_00_c000_0083, 64'h4a_01_c2_00_c000_00c2,
        64'h4a_00_05_00_c000_0005, 64'h4a_01_44_00_c000_0044,
        64'h4a_00_86_00_c000_0086, 64'h4a_01_c5_00_c000_00c5
    };

    // Expected host TX words per stream with index lane * NUM_FUNCS + function
    pcie_tlp_pkg::tlp_t      exp_q [2 * pcie_tlp_pkg::NUM_FUNCS][$];
    pcie_tlp_pkg::tlp_t      cpl_q [pcie_tlp_pkg::NUM_FUNCS][$];
    bit                      cmt_pending [256];
    pcie_tlp_pkg::func_num_t cmt_func [256];
    int                      cmt_outstanding = 0;
    int                      check_count = 0;
    int                      error_count = 0;
    int                      cycle_count = 0;

    host_chan_mux_top UUT
    (
        .clk             (clk),
        .rst_n           (rst_n),
        .afu_tx_a_valid  (afu_tx_a_valid),
        .afu_tx_a_data   (afu_tx_a_data),
        .afu_tx_a_ready  (afu_tx_a_ready),
        .afu_tx_b_valid  (afu_tx_b_valid),
        .afu_tx_b_data   (afu_tx_b_data),
        .afu_tx_b_ready  (afu_tx_b_ready),
        .afu_rx_a_valid  (afu_rx_a_valid),
        .afu_rx_a_data   (afu_rx_a_data),
        .afu_rx_a_ready  (afu_rx_a_ready),
        .afu_rx_b_valid  (afu_rx_b_valid),
        .afu_rx_b_data   (afu_rx_b_data),
        .afu_rx_b_ready  (afu_rx_b_ready),
        .host_tx_valid   (host_tx_valid),
        .host_tx_data    (host_tx_data),
        .host_tx_ready   (host_tx_ready),
        .host_rx_a_valid (host_rx_a_valid),
        .host_rx_a_data  (host_rx_a_data),
        .host_rx_a_ready (host_rx_a_ready)
    );

    always #10 clk = ~clk;

    // Builds a word from its fields with the reserved byte right above the payload
    function automatic pcie_tlp_pkg::tlp_t make_tlp(input pcie_tlp_pkg::tlp_kind_t kind,
                                                    input pcie_tlp_pkg::func_num_t fn,
                                                    input pcie_tlp_pkg::tlp_tag_t tag,
                                                    input logic [7:0] rsvd,
                                                    input pcie_tlp_pkg::tlp_payload_t payload);
        pcie_tlp_pkg::tlp_t word;
        word = '0;
        word[pcie_tlp_pkg::KIND_LSB +: 8] = kind;
        word[pcie_tlp_pkg::FUNC_LSB +: 8] = fn;
        word[pcie_tlp_pkg::TAG_LSB +: 8]  = tag;
        word[32 +: 8]                     = rsvd;
        word[0 +: 32]                     = payload;
        return word;
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("%0t ns: %s", $time, msg);
    endtask

    task automatic compare_tlp(input string name, input pcie_tlp_pkg::tlp_t expected,
                               input pcie_tlp_pkg::tlp_t actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic compare_func(input string name, input pcie_tlp_pkg::func_num_t expected,
                                input pcie_tlp_pkg::func_num_t actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic set_afu_tx(input int lane, input int fn, input logic valid,
                              input pcie_tlp_pkg::tlp_t data);
        if (lane == 0)
        begin
            afu_tx_a_valid[fn] = valid;
            afu_tx_a_data[fn]  = data;
        end
        else
        begin
            afu_tx_b_valid[fn] = valid;
            afu_tx_b_data[fn]  = data;
        end
    endtask

    function automatic logic afu_tx_taken(input int lane, input int fn);
        return (lane == 0) ? afu_tx_a_ready[fn] : afu_tx_b_ready[fn];
    endfunction

    // One AFU port walks the table and sends only its own entries in table order
    task automatic drive_afu_port(input int lane, input int fn);
        logic [63:0] entry;
        logic        taken;
        for (int i = 0; i < $size(stim_table); i++)
        begin
            entry = stim_table[i];
            if ((int'(entry[63:56]) == lane) && (int'(entry[55:48]) == fn))
            begin
                // A foreign func value goes in so the stamping shows on host TX
                set_afu_tx(lane, fn, 1'b1,
                           make_tlp(entry[47:40], 8'hee, entry[39:32], 8'hc3, entry[31:0]));
                taken = 1'b0;
                while (!taken)
                begin
                    @(posedge clk);
                    taken = afu_tx_taken(lane, fn);
                end
                @(negedge clk);
                set_afu_tx(lane, fn, 1'b0, '0);
                repeat ($urandom % 3) @(negedge clk);
            end
        end
    endtask

    // Host side sends the completions one by one on RX A
    task automatic drive_host_rx();
        logic taken;
        repeat (10) @(negedge clk);
        for (int i = 0; i < $size(cpl_table); i++)
        begin
            host_rx_a_valid = 1'b1;
            host_rx_a_data  = cpl_table[i];
            taken = 1'b0;
            while (!taken)
            begin
                @(posedge clk);
                taken = host_rx_a_ready;
            end
            @(negedge clk);
            host_rx_a_valid = 1'b0;
            repeat ($urandom % 3) @(negedge clk);
        end
    endtask

    // An accepted AFU word is expected on host TX with the port index as its function
    task automatic record_afu_tx(input int lane, input int fn, input pcie_tlp_pkg::tlp_t data);
        pcie_tlp_pkg::tlp_t     expected;
        pcie_tlp_pkg::tlp_tag_t tag;
        expected = data;
        expected[pcie_tlp_pkg::FUNC_LSB +: 8] = pcie_tlp_pkg::func_num_t'(fn);
        exp_q[lane * pcie_tlp_pkg::NUM_FUNCS + fn].push_back(expected);
        tag = data[pcie_tlp_pkg::TAG_LSB +: 8];
        if (data[pcie_tlp_pkg::KIND_LSB +: 8] == pcie_tlp_pkg::KIND_MWR)
        begin
            cmt_pending[tag] = 1'b1;
            cmt_func[tag]    = pcie_tlp_pkg::func_num_t'(fn);
            cmt_outstanding++;
        end
    endtask

    // A host TX beat must match the head of exactly one stream
    task automatic check_host_tx(input pcie_tlp_pkg::tlp_t actual);
        int                 idx;
        pcie_tlp_pkg::tlp_t head;
        idx = -1;
        for (int q = 0; q < 2 * pcie_tlp_pkg::NUM_FUNCS; q++)
        begin
            if (exp_q[q].size() > 0)
            begin
                head = exp_q[q][0];
                if (head[pcie_tlp_pkg::TAG_LSB +: 8] == actual[pcie_tlp_pkg::TAG_LSB +: 8])
                    idx = q;
            end
        end
        if (idx < 0)
            report_error($sformatf("host_tx sent %h, which is no pending stream head", actual));
        else
        begin
            compare_func("host_tx_data func",
                         pcie_tlp_pkg::func_num_t'(idx % pcie_tlp_pkg::NUM_FUNCS),
                         actual[pcie_tlp_pkg::FUNC_LSB +: 8]);
            compare_tlp("host_tx_data", exp_q[idx].pop_front(), actual);
        end
    endtask

    task automatic check_commit(input int fn, input pcie_tlp_pkg::tlp_t actual);
        pcie_tlp_pkg::tlp_tag_t tag;
        tag = actual[pcie_tlp_pkg::TAG_LSB +: 8];
        if (!cmt_pending[tag])
            report_error($sformatf("Commit on afu_rx_b[%0d] for tag %h without a write", fn, tag));
        else
        begin
            compare_tlp("afu_rx_b_data",
                        make_tlp(pcie_tlp_pkg::KIND_CMT, cmt_func[tag], tag, 8'h00, 32'h0),
                        actual);
            compare_func("afu_rx_b port", cmt_func[tag], pcie_tlp_pkg::func_num_t'(fn));
            cmt_pending[tag] = 1'b0;
            cmt_outstanding--;
        end
    endtask

    task automatic check_cpl(input int fn, input pcie_tlp_pkg::tlp_t actual);
        if (cpl_q[fn].size() == 0)
            report_error($sformatf("Completion on afu_rx_a[%0d] that the host never sent", fn));
        else
            compare_tlp("afu_rx_a_data", cpl_q[fn].pop_front(), actual);
    endtask

    task automatic check_idle(input string when);
        if (host_tx_valid !== 1'b0)
            report_error($sformatf("host_tx_valid is not low %s", when));
        for (int f = 0; f < pcie_tlp_pkg::NUM_FUNCS; f++)
        begin
            if (afu_rx_a_valid[f] !== 1'b0)
                report_error($sformatf("afu_rx_a_valid[%0d] is not low %s", f, when));
            if (afu_rx_b_valid[f] !== 1'b0)
                report_error($sformatf("afu_rx_b_valid[%0d] is not low %s", f, when));
        end
    endtask

    function automatic logic all_drained();
        logic empty;
        empty = (cmt_outstanding == 0);
        for (int q = 0; q < 2 * pcie_tlp_pkg::NUM_FUNCS; q++)
        begin
            if (exp_q[q].size() != 0)
                empty = 1'b0;
        end
        for (int f = 0; f < pcie_tlp_pkg::NUM_FUNCS; f++)
        begin
            if (cpl_q[f].size() != 0)
                empty = 1'b0;
        end
        return empty;
    endfunction

    // Monitor samples every handshake at the rising edge and records before it checks
    always @(posedge clk)
    begin
        if (rst_n === 1'b1)
        begin
            for (int f = 0; f < pcie_tlp_pkg::NUM_FUNCS; f++)
            begin
                if (afu_tx_a_valid[f] && afu_tx_a_ready[f])
                    record_afu_tx(0, f, afu_tx_a_data[f]);
                if (afu_tx_b_valid[f] && afu_tx_b_ready[f])
                    record_afu_tx(1, f, afu_tx_b_data[f]);
            end
            if (host_rx_a_valid && host_rx_a_ready)
                cpl_q[int'(host_rx_a_data[pcie_tlp_pkg::FUNC_LSB +: 8])].push_back(host_rx_a_data);
            if (host_tx_valid && host_tx_ready)
                check_host_tx(host_tx_data);
            for (int f = 0; f < pcie_tlp_pkg::NUM_FUNCS; f++)
            begin
                // A valid RX word may only show at the port its func field names
                if (afu_rx_a_valid[f])
                    compare_func("afu_rx_a route", pcie_tlp_pkg::func_num_t'(f),
                                 afu_rx_a_data[f][pcie_tlp_pkg::FUNC_LSB +: 8]);
                if (afu_rx_a_valid[f] && afu_rx_a_ready[f])
                    check_cpl(f, afu_rx_a_data[f]);
                if (afu_rx_b_valid[f] && afu_rx_b_ready[f])
                    check_commit(f, afu_rx_b_data[f]);
            end
        end
    end

    // Host and AFU RX back-pressure keeps ready high about 70 percent of the time
    initial
    begin
        host_tx_ready = 1'b0;
        for (int f = 0; f < pcie_tlp_pkg::NUM_FUNCS; f++)
        begin
            afu_rx_a_ready[f] = 1'b0;
            afu_rx_b_ready[f] = 1'b0;
        end
        forever
        begin
            @(negedge clk);
            host_tx_ready = (($urandom % 100) < 70);
            for (int f = 0; f < pcie_tlp_pkg::NUM_FUNCS; f++)
            begin
                afu_rx_a_ready[f] = (($urandom % 100) < 70);
                afu_rx_b_ready[f] = (($urandom % 100) < 70);
            end
        end
    end

    initial
    begin
        int limit;
        limit = 40 * ($size(stim_table) + $size(cpl_table)) + 200;
        while (cycle_count < limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        report_error($sformatf("Timeout after %0d cycles with TLPs still in flight", limit));
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h0b8a3739));
        rst_n           = 1'b0;
        host_rx_a_valid = 1'b0;
        host_rx_a_data  = '0;
        for (int f = 0; f < pcie_tlp_pkg::NUM_FUNCS; f++)
        begin
            set_afu_tx(0, f, 1'b0, '0);
            set_afu_tx(1, f, 1'b0, '0);
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_idle("right after reset");

        // All four AFU ports and the host completions run at once
        fork
            drive_afu_port(0, 0);
            drive_afu_port(0, 1);
            drive_afu_port(1, 0);
            drive_afu_port(1, 1);
            drive_host_rx();
        join

        while (!all_drained())
            @(negedge clk);
        repeat (4) @(negedge clk);
        check_idle("after the last TLP drained");

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: flist.f
pcie_tlp_pkg.sv
pf_vf_mux.sv
tx_ab_arb.sv
local_commit.sv
host_chan_mux_top.sv
tb_host_chan_mux.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the host-channel mux testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_host_chan_mux -o tb_sim \
    && ./obj_dir/tb_sim 2>&1 | tee sim.log \
    && ! grep -q "Result: FAILED" sim.log \
    && grep -q "Result: PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
